// ==== sim.f ====
cc_pkg.sv
spill_register.sv
ipu_mul.sv
ipu_div.sv
ipu.sv
core_complex.sv
core_complex_properties.sv
tb_checker.sv
tb_core_complex.sv

// ==== Bender.yml ====
package:
  name: core_complex

sources:
  # Design
  - cc_pkg.sv
  - spill_register.sv
  - ipu_mul.sv
  - ipu_div.sv
  - ipu.sv
  - core_complex.sv
  # Testbench
  - target: test
    files:
      - core_complex_properties.sv
      - tb_checker.sv
      - tb_core_complex.sv

// ==== tb_core_complex.sv ====
// --------------------
// Testbench top: clock, reset, offload table, TCDM traffic,
// memory model and watchdog
// --------------------
`timescale 1ns/100ps
`default_nettype none

module tb_core_complex;
  import cc_pkg::*;

  localparam int          ClkPeriod      = 100;
  localparam int          NumOps         = 23;
  localparam int          NumTcdm        = 12;
  localparam int          NumTests       = NumOps + NumTcdm;
  localparam int          WatchdogCycles = NumOps * 60 + 200;
  localparam logic [31:0] RespXor        = 32'hA5A5_5A5A;

  typedef struct packed {
    logic [3:0]           op;
    logic [DataWidth-1:0] arga;
    logic [DataWidth-1:0] argb;
    logic [DataWidth-1:0] exp_data;
    logic                 exp_err;
  } vec_t;

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  acc_req_t  acc_req;
  acc_resp_t acc_resp, exp_resp;
  logic      acc_req_valid, acc_req_ready, acc_resp_valid, acc_resp_ready;
  dreq_t     core_req, mem_req;
  dresp_t    core_resp, mem_resp;
  logic      core_req_valid, core_req_ready, core_resp_valid, core_resp_ready;
  logic      mem_req_valid, mem_req_ready, mem_resp_valid, mem_resp_ready;
  logic      resp_taken = 1'b0;
  logic [31:0] lfsr_q   = 32'h942b;
  dresp_t    mem_q [$];
  vec_t      vec_tbl [NumOps];
  int        n_pass, n_fail, n_done;

  always #(ClkPeriod / 2) clk = ~clk;

  core_complex #(
    .RegisterOffloadReq  ( 1'b1 ),
    .RegisterOffloadResp ( 1'b1 ),
    .RegisterTCDMReq     ( 1'b1 ),
    .RegisterTCDMResp    ( 1'b1 )
  ) uut (
    .clk_i             ( clk             ),
    .rst_i             ( rst             ),
    .acc_req_i         ( acc_req         ),
    .acc_req_valid_i   ( acc_req_valid   ),
    .acc_req_ready_o   ( acc_req_ready   ),
    .acc_resp_o        ( acc_resp        ),
    .acc_resp_valid_o  ( acc_resp_valid  ),
    .acc_resp_ready_i  ( acc_resp_ready  ),
    .data_req_i        ( core_req        ),
    .data_req_valid_i  ( core_req_valid  ),
    .data_req_ready_o  ( core_req_ready  ),
    .data_resp_o       ( core_resp       ),
    .data_resp_valid_o ( core_resp_valid ),
    .data_resp_ready_i ( core_resp_ready ),
    .data_req_o        ( mem_req         ),
    .data_req_valid_o  ( mem_req_valid   ),
    .data_req_ready_i  ( mem_req_ready   ),
    .data_resp_i       ( mem_resp        ),
    .data_resp_valid_i ( mem_resp_valid  ),
    .data_resp_ready_o ( mem_resp_ready  )
  );

  tb_checker #(
    .RespXor ( RespXor )
  ) i_checker (
    .clk_i            ( clk                              ),
    .rst_i            ( rst                              ),
    .acc_req_i        ( acc_req                          ),
    .acc_req_fire_i   ( acc_req_valid && acc_req_ready   ),
    .exp_i            ( exp_resp                         ),
    .acc_resp_i       ( acc_resp                         ),
    .acc_resp_fire_i  ( acc_resp_valid && acc_resp_ready ),
    .core_req_i       ( core_req                         ),
    .core_req_fire_i  ( core_req_valid && core_req_ready ),
    .mem_req_i        ( mem_req                          ),
    .mem_req_fire_i   ( mem_req_valid && mem_req_ready   ),
    .core_resp_i      ( core_resp                        ),
    .core_resp_fire_i ( core_resp_valid && core_resp_ready ),
    .n_pass_o         ( n_pass                           ),
    .n_fail_o         ( n_fail                           ),
    .n_done_o         ( n_done                           )
  );

  bind core_complex core_complex_properties i_core_complex_properties (
    .clk_i             ( clk_i             ),
    .rst_i             ( rst_i             ),
    .acc_req_i         ( acc_req_i         ),
    .acc_req_valid_i   ( acc_req_valid_i   ),
    .acc_req_ready_i   ( acc_req_ready_o   ),
    .acc_resp_i        ( acc_resp_o        ),
    .acc_resp_valid_i  ( acc_resp_valid_o  ),
    .acc_resp_ready_i  ( acc_resp_ready_i  ),
    .mem_req_i         ( data_req_o        ),
    .mem_req_valid_i   ( data_req_valid_o  ),
    .mem_req_ready_i   ( data_req_ready_i  ),
    .tcdm_resp_i       ( data_resp_o       ),
    .tcdm_resp_valid_i ( data_resp_valid_o ),
    .tcdm_resp_ready_i ( data_resp_ready_i )
  );

  // --------------------
  // Stimulus helpers
  // --------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    // Taps for x^32 + x^22 + x^2 + x + 1
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bit(output logic b);
    lfsr_q = lfsr_step(lfsr_q);
    b      = lfsr_q[0];
  endtask

  function automatic vec_t make_vec(input logic [3:0] op, input logic [31:0] a,
                                    input logic [31:0] b, input logic [31:0] res,
                                    input logic err);
    return '{op: op, arga: a, argb: b, exp_data: res, exp_err: err};
  endfunction

  // Divides are mixed in so later multiplies overtake them
  task automatic load_vectors();
    vec_tbl[0]  = make_vec(MUL,    32'h0000_0007, 32'h0000_0006, 32'h0000_002A, 1'b0);
    vec_tbl[1]  = make_vec(DIV,    32'h0000_0014, 32'hFFFF_FFFD, 32'hFFFF_FFFA, 1'b0);
    vec_tbl[2]  = make_vec(MULH,   32'hFFFF_FFFF, 32'h0000_0005, 32'hFFFF_FFFF, 1'b0);
    vec_tbl[3]  = make_vec(MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 1'b0);
    vec_tbl[4]  = make_vec(REM,    32'h0000_0014, 32'hFFFF_FFFD, 32'h0000_0002, 1'b0);
    vec_tbl[5]  = make_vec(MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
    vec_tbl[6]  = make_vec(4'd9,   32'h1234_5678, 32'h0000_0001, 32'h0000_0000, 1'b1);
    vec_tbl[7]  = make_vec(DIVU,   32'h0000_0064, 32'h0000_0007, 32'h0000_000E, 1'b0);
    vec_tbl[8]  = make_vec(MUL,    32'hFFFF_FFFF, 32'h0000_0005, 32'hFFFF_FFFB, 1'b0);
    vec_tbl[9]  = make_vec(REMU,   32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 1'b0);
    vec_tbl[10] = make_vec(MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 1'b0);
    vec_tbl[11] = make_vec(DIV,    32'h0000_0005, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0);
    vec_tbl[12] = make_vec(REM,    32'h0000_0005, 32'h0000_0000, 32'h0000_0005, 1'b0);
    vec_tbl[13] = make_vec(DIV,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 1'b0);
    vec_tbl[14] = make_vec(MULHU,  32'h1234_5678, 32'h0000_0010, 32'h0000_0001, 1'b0);
    vec_tbl[15] = make_vec(REM,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
    vec_tbl[16] = make_vec(4'd15,  32'hDEAD_BEEF, 32'hCAFE_F00D, 32'h0000_0000, 1'b1);
    vec_tbl[17] = make_vec(REM,    32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFF, 1'b0);
    vec_tbl[18] = make_vec(MUL,    32'h0001_0000, 32'h0001_0000, 32'h0000_0000, 1'b0);
    vec_tbl[19] = make_vec(DIVU,   32'h0000_1234, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0);
    vec_tbl[20] = make_vec(REMU,   32'h0000_1234, 32'h0000_0000, 32'h0000_1234, 1'b0);
    vec_tbl[21] = make_vec(MULHSU, 32'h0000_0002, 32'h8000_0000, 32'h0000_0001, 1'b0);
    vec_tbl[22] = make_vec(DIV,    32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFD, 1'b0);
  endtask

  task automatic drive_offloads();
    for (int i = 0; i < NumOps; i++) begin
      @(negedge clk);
      acc_req = '{id: IdWidth'(i % 32), op: ipu_op_e'(vec_tbl[i].op),
                  arga: vec_tbl[i].arga, argb: vec_tbl[i].argb};
      exp_resp = '{id: IdWidth'(i % 32), data: vec_tbl[i].exp_data,
                   error: vec_tbl[i].exp_err};
      acc_req_valid = 1'b1;
      @(posedge clk);
      while (!acc_req_ready) @(posedge clk);
    end
    @(negedge clk);
    acc_req_valid = 1'b0;
  endtask

  task automatic drive_tcdm();
    for (int i = 0; i < NumTcdm; i++) begin
      @(negedge clk);
      core_req = '{addr: 32'h0001_0000 + 32'(i * 4), write: 1'(i % 2), amo: 4'(i % 3),
                   data: 32'hC0DE_0000 + 32'(i), strb: 4'(i + 1), id: IdWidth'(i)};
      core_req_valid = 1'b1;
      @(posedge clk);
      while (!core_req_ready) @(posedge clk);
    end
    @(negedge clk);
    core_req_valid = 1'b0;
  endtask

  initial begin
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

  // Random back-pressure, about three in four cycles ready
  initial begin
    logic b0, b1;
    acc_resp_ready  = 1'b0;
    mem_req_ready   = 1'b0;
    core_resp_ready = 1'b0;
    @(negedge rst);
    forever begin
      @(negedge clk);
      take_bit(b0);
      take_bit(b1);
      acc_resp_ready = b0 | b1;
      take_bit(b0);
      take_bit(b1);
      mem_req_ready = b0 | b1;
      take_bit(b0);
      take_bit(b1);
      core_resp_ready = b0 | b1;
    end
  end

  // --------------------
  // Memory model
  // --------------------
  always @(posedge clk) begin
    dresp_t rsp;
    if (!rst && mem_req_valid && mem_req_ready) begin
      rsp = '{id: mem_req.id, data: mem_req.addr ^ RespXor, error: 1'b0};
      mem_q.push_back(rsp);
    end
    resp_taken <= mem_resp_valid && mem_resp_ready;
  end

  initial begin
    mem_resp       = '0;
    mem_resp_valid = 1'b0;
    forever begin
      @(negedge clk);
      if (resp_taken) mem_resp_valid = 1'b0;
      if (!mem_resp_valid && mem_q.size() > 0) begin
        mem_resp       = mem_q.pop_front();
        mem_resp_valid = 1'b1;
      end
    end
  end

  initial begin
    acc_req        = '0;
    acc_req_valid  = 1'b0;
    exp_resp       = '0;
    core_req       = '0;
    core_req_valid = 1'b0;
    load_vectors();
    @(negedge rst);
    fork
      drive_offloads();
      drive_tcdm();
    join
    while (n_done < NumTests) @(negedge clk);
    // Room for late duplicates to show up
    repeat (20) @(negedge clk);
    $display("Tests: %0d passed, %0d failed checks, %0d assertion failures, %0d of %0d finished",
             n_pass, n_fail, uut.i_core_complex_properties.n_errors, n_done, NumTests);
    if (n_fail == 0 && n_pass == NumTests &&
        uut.i_core_complex_properties.n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: only %0d of %0d tests finished within %0d cycles",
             n_done, NumTests, WatchdogCycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
// --------------------
// Scoreboard for the offload and TCDM ports of the core complex
// --------------------
`timescale 1ns/100ps
`default_nettype none

module tb_checker #(
  parameter logic [31:0] RespXor = 32'hA5A5_5A5A
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cc_pkg::acc_req_t  acc_req_i,
  input  logic              acc_req_fire_i,
  input  cc_pkg::acc_resp_t exp_i,
  input  cc_pkg::acc_resp_t acc_resp_i,
  input  logic              acc_resp_fire_i,
  input  cc_pkg::dreq_t     core_req_i,
  input  logic              core_req_fire_i,
  input  cc_pkg::dreq_t     mem_req_i,
  input  logic              mem_req_fire_i,
  input  cc_pkg::dresp_t    core_resp_i,
  input  logic              core_resp_fire_i,
  output int                n_pass_o,
  output int                n_fail_o,
  output int                n_done_o
);
  import cc_pkg::*;

  typedef struct packed {
    dresp_t resp;
    logic   req_ok;
  } tcdm_exp_t;

  // Expected offload answers, indexed by ID
  acc_resp_t              pend_q [2**IdWidth];
  logic [2**IdWidth-1:0]  pend_valid = '0;
  dreq_t                  req_q [$];
  tcdm_exp_t              resp_q [$];
  int                     n_pass = 0;
  int                     n_fail = 0;
  int                     n_done = 0;

  always @(posedge clk_i) begin
    dreq_t     req;
    tcdm_exp_t ent;
    acc_resp_t want;
    if (!rst_i) begin
      // --------------------
      // Offload path
      // --------------------
      if (acc_resp_fire_i) begin
        if (!pend_valid[acc_resp_i.id]) begin
          $display("ERROR %0t: response for ID %0d has no outstanding request",
                   $time, acc_resp_i.id);
          n_fail++;
        end else begin
          want = pend_q[acc_resp_i.id];
          pend_valid[acc_resp_i.id] = 1'b0;
          n_done++;
          if (acc_resp_i.data !== want.data) begin
            $display("FAILED %0t acc_resp_o.data id %0d: got %h expected %h",
                     $time, acc_resp_i.id, acc_resp_i.data, want.data);
            n_fail++;
          end else if (acc_resp_i.error !== want.error) begin
            $display("FAILED %0t acc_resp_o.error id %0d: got %b expected %b",
                     $time, acc_resp_i.id, acc_resp_i.error, want.error);
            n_fail++;
          end else begin
            $display("PASS   offload id %0d data %h error %b",
                     acc_resp_i.id, acc_resp_i.data, acc_resp_i.error);
            n_pass++;
          end
        end
      end
      if (acc_req_fire_i) begin
        if (pend_valid[acc_req_i.id]) begin
          $display("ERROR %0t: offload ID %0d reused while still outstanding",
                   $time, acc_req_i.id);
          n_fail++;
        end
        pend_q[acc_req_i.id]     = exp_i;
        pend_valid[acc_req_i.id] = 1'b1;
      end

      // --------------------
      // TCDM path
      // --------------------
      if (core_req_fire_i) begin
        req_q.push_back(core_req_i);
      end
      if (mem_req_fire_i) begin
        if (req_q.size() == 0) begin
          $display("ERROR %0t: memory-side request without a core-side request", $time);
          n_fail++;
        end else begin
          req         = req_q.pop_front();
          ent.resp    = '{id: req.id, data: req.addr ^ RespXor, error: 1'b0};
          ent.req_ok  = (mem_req_i === req);
          if (!ent.req_ok) begin
            $display("FAILED %0t data_req_o: got %h expected %h", $time, mem_req_i, req);
            n_fail++;
          end
          resp_q.push_back(ent);
        end
      end
      if (core_resp_fire_i) begin
        if (resp_q.size() == 0) begin
          $display("ERROR %0t: TCDM response without a request", $time);
          n_fail++;
        end else begin
          ent = resp_q.pop_front();
          n_done++;
          if (core_resp_i !== ent.resp) begin
            $display("FAILED %0t data_resp_o: got %h expected %h",
                     $time, core_resp_i, ent.resp);
            n_fail++;
          end else if (!ent.req_ok) begin
            $display("tcdm id %0d finished after a wrong request", core_resp_i.id);
          end else begin
            $display("PASS   tcdm id %0d data %h", core_resp_i.id, core_resp_i.data);
            n_pass++;
          end
        end
      end
    end
  end

  assign n_pass_o = n_pass;
  assign n_fail_o = n_fail;
  assign n_done_o = n_done;

endmodule

`default_nettype wire

// ==== core_complex_properties.sv ====
// --------------------
// Handshake assertions bound into the core complex
// --------------------
`timescale 1ns/100ps
`default_nettype none

module core_complex_properties (
  input logic              clk_i,
  input logic              rst_i,
  input cc_pkg::acc_req_t  acc_req_i,
  input logic              acc_req_valid_i,
  input logic              acc_req_ready_i,
  input cc_pkg::acc_resp_t acc_resp_i,
  input logic              acc_resp_valid_i,
  input logic              acc_resp_ready_i,
  input cc_pkg::dreq_t     mem_req_i,
  input logic              mem_req_valid_i,
  input logic              mem_req_ready_i,
  input cc_pkg::dresp_t    tcdm_resp_i,
  input logic              tcdm_resp_valid_i,
  input logic              tcdm_resp_ready_i
);

  // Failed assertions so far
  int unsigned n_errors = 0;

  // Stalled payloads hold until taken
  a_acc_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_req_valid_i && !acc_req_ready_i |=> acc_req_valid_i && $stable(acc_req_i))
    else begin
      n_errors++;
      $error("offload request changed while stalled");
    end

  a_acc_resp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_resp_valid_i && !acc_resp_ready_i |=> acc_resp_valid_i && $stable(acc_resp_i))
    else begin
      n_errors++;
      $error("offload response changed while stalled");
    end

  a_mem_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
    else begin
      n_errors++;
      $error("memory-side TCDM request changed while stalled");
    end

  a_tcdm_resp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    tcdm_resp_valid_i && !tcdm_resp_ready_i |=> tcdm_resp_valid_i && $stable(tcdm_resp_i))
    else begin
      n_errors++;
      $error("core-side TCDM response changed while stalled");
    end

  // Outputs quiet in the first cycle out of reset
  a_quiet_after_reset: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !acc_resp_valid_i && !mem_req_valid_i && !tcdm_resp_valid_i)
    else begin
      n_errors++;
      $error("valid output high right after reset");
    end

endmodule

`default_nettype wire

// ==== core_complex.sv ====
// --------------------
// Core complex top: four cut registers around the IPU and TCDM paths
// --------------------
`timescale 1ns/100ps
`default_nettype none

module core_complex #(
  parameter bit RegisterOffloadReq  = 1'b1,
  parameter bit RegisterOffloadResp = 1'b1,
  parameter bit RegisterTCDMReq     = 1'b0,
  parameter bit RegisterTCDMResp    = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // Core-side offload port
  input  cc_pkg::acc_req_t  acc_req_i,
  input  logic              acc_req_valid_i,
  output logic              acc_req_ready_o,
  output cc_pkg::acc_resp_t acc_resp_o,
  output logic              acc_resp_valid_o,
  input  logic              acc_resp_ready_i,
  // Core-side TCDM port
  input  cc_pkg::dreq_t     data_req_i,
  input  logic              data_req_valid_i,
  output logic              data_req_ready_o,
  output cc_pkg::dresp_t    data_resp_o,
  output logic              data_resp_valid_o,
  input  logic              data_resp_ready_i,
  // Memory-side TCDM port
  output cc_pkg::dreq_t     data_req_o,
  output logic              data_req_valid_o,
  input  logic              data_req_ready_i,
  input  cc_pkg::dresp_t    data_resp_i,
  input  logic              data_resp_valid_i,
  output logic              data_resp_ready_o
);
  import cc_pkg::*;

  // IPU side of the offload cut registers
  acc_req_t  acc_req_q;
  acc_resp_t acc_resp_d;
  logic      acc_req_q_valid, acc_req_q_ready;
  logic      acc_resp_d_valid, acc_resp_d_ready;

  // Cut offload request path
  spill_register #(
    .Bypass ( !RegisterOffloadReq ),
    .T      ( acc_req_t           )
  ) i_spill_register_acc_req (
    .clk_i   ( clk_i           ),
    .rst_i   ( rst_i           ),
    .valid_i ( acc_req_valid_i ),
    .ready_o ( acc_req_ready_o ),
    .data_i  ( acc_req_i       ),
    .valid_o ( acc_req_q_valid ),
    .ready_i ( acc_req_q_ready ),
    .data_o  ( acc_req_q       )
  );

  ipu i_ipu (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .acc_req_i        ( acc_req_q        ),
    .acc_req_valid_i  ( acc_req_q_valid  ),
    .acc_req_ready_o  ( acc_req_q_ready  ),
    .acc_resp_o       ( acc_resp_d       ),
    .acc_resp_valid_o ( acc_resp_d_valid ),
    .acc_resp_ready_i ( acc_resp_d_ready )
  );

  // Cut offload response path
  spill_register #(
    .Bypass ( !RegisterOffloadResp ),
    .T      ( acc_resp_t           )
  ) i_spill_register_acc_resp (
    .clk_i   ( clk_i            ),
    .rst_i   ( rst_i            ),
    .valid_i ( acc_resp_d_valid ),
    .ready_o ( acc_resp_d_ready ),
    .data_i  ( acc_resp_d       ),
    .valid_o ( acc_resp_valid_o ),
    .ready_i ( acc_resp_ready_i ),
    .data_o  ( acc_resp_o       )
  );

  // Cut TCDM request path
  spill_register #(
    .Bypass ( !RegisterTCDMReq ),
    .T      ( dreq_t           )
  ) i_spill_register_tcdm_req (
    .clk_i   ( clk_i            ),
    .rst_i   ( rst_i            ),
    .valid_i ( data_req_valid_i ),
    .ready_o ( data_req_ready_o ),
    .data_i  ( data_req_i       ),
    .valid_o ( data_req_valid_o ),
    .ready_i ( data_req_ready_i ),
    .data_o  ( data_req_o       )
  );

  // Cut TCDM response path
  spill_register #(
    .Bypass ( !RegisterTCDMResp ),
    .T      ( dresp_t           )
  ) i_spill_register_tcdm_resp (
    .clk_i   ( clk_i             ),
    .rst_i   ( rst_i             ),
    .valid_i ( data_resp_valid_i ),
    .ready_o ( data_resp_ready_o ),
    .data_i  ( data_resp_i       ),
    .valid_o ( data_resp_valid_o ),
    .ready_i ( data_resp_ready_i ),
    .data_o  ( data_resp_o       )
  );

endmodule

`default_nettype wire

// ==== ipu.sv ====
// --------------------
// Integer processing unit: opcode dispatch, illegal-op answers and
// response arbitration over the multiplier and divider
// --------------------
`timescale 1ns/100ps
`default_nettype none

module ipu (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cc_pkg::acc_req_t  acc_req_i,
  input  logic              acc_req_valid_i,
  output logic              acc_req_ready_o,
  output cc_pkg::acc_resp_t acc_resp_o,
  output logic              acc_resp_valid_o,
  input  logic              acc_resp_ready_i
);
  import cc_pkg::*;

  logic               sel_mul, sel_div, sel_err;
  logic               mul_in_ready, div_in_ready, err_in_ready;
  logic               mul_valid, mul_ready, div_valid, div_ready;
  acc_resp_t          mul_resp, div_resp, err_resp;
  logic               err_valid_q;
  logic [IdWidth-1:0] err_id_q;
  // Grant bits: 2 illegal, 1 divider, 0 multiplier
  logic [2:0]         gnt, gnt_q;
  logic               lock_q;

  // --------------------
  // Decode
  // --------------------
  always_comb begin
    sel_mul = 1'b0;
    sel_div = 1'b0;
    sel_err = 1'b0;
    case (acc_req_i.op)
      MUL, MULH, MULHSU, MULHU: sel_mul = 1'b1;
      DIV, DIVU, REM, REMU:     sel_div = 1'b1;
      default:                  sel_err = 1'b1;
    endcase
  end

  assign acc_req_ready_o = (sel_mul && mul_in_ready) || (sel_div && div_in_ready) ||
                           (sel_err && err_in_ready);

  ipu_mul i_ipu_mul (
    .clk_i       ( clk_i                       ),
    .rst_i       ( rst_i                       ),
    .in_valid_i  ( acc_req_valid_i && sel_mul  ),
    .in_ready_o  ( mul_in_ready                ),
    .req_i       ( acc_req_i                   ),
    .out_valid_o ( mul_valid                   ),
    .out_ready_i ( mul_ready                   ),
    .resp_o      ( mul_resp                    )
  );

  ipu_div i_ipu_div (
    .clk_i       ( clk_i                       ),
    .rst_i       ( rst_i                       ),
    .in_valid_i  ( acc_req_valid_i && sel_div  ),
    .in_ready_o  ( div_in_ready                ),
    .req_i       ( acc_req_i                   ),
    .out_valid_o ( div_valid                   ),
    .out_ready_i ( div_ready                   ),
    .resp_o      ( div_resp                    )
  );

  // --------------------
  // Illegal opcode slot
  // --------------------
  assign err_in_ready = !err_valid_q || (gnt[2] && acc_resp_ready_i);
  assign err_resp     = '{id: err_id_q, data: '0, error: 1'b1};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      err_valid_q <= 1'b0;
    end else if (acc_req_valid_i && sel_err && err_in_ready) begin
      err_valid_q <= 1'b1;
    end else if (gnt[2] && acc_resp_ready_i) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_req_valid_i && sel_err && err_in_ready) begin
      err_id_q <= acc_req_i.id;
    end
  end

  // --------------------
  // Response arbiter
  // --------------------
  // Grant is held while stalled so the offered payload stays put
  always_comb begin
    if (lock_q) begin
      gnt = gnt_q;
    end else if (err_valid_q) begin
      gnt = 3'b100;
    end else if (div_valid) begin
      gnt = 3'b010;
    end else if (mul_valid) begin
      gnt = 3'b001;
    end else begin
      gnt = 3'b000;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      lock_q <= 1'b0;
      gnt_q  <= 3'b000;
    end else begin
      lock_q <= acc_resp_valid_o && !acc_resp_ready_i;
      gnt_q  <= gnt;
    end
  end

  assign acc_resp_valid_o = (gnt[2] && err_valid_q) || (gnt[1] && div_valid) ||
                            (gnt[0] && mul_valid);
  assign div_ready  = gnt[1] && acc_resp_ready_i;
  assign mul_ready  = gnt[0] && acc_resp_ready_i;
  assign acc_resp_o = gnt[2] ? err_resp : (gnt[1] ? div_resp : mul_resp);

endmodule

`default_nettype wire

// ==== ipu_div.sv ====
// --------------------
// Serial restoring divider for DIV, DIVU, REM and REMU
// --------------------
`timescale 1ns/100ps
`default_nettype none

module ipu_div (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  cc_pkg::acc_req_t  req_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output cc_pkg::acc_resp_t resp_o
);
  import cc_pkg::*;

  localparam int CntWidth = $clog2(DataWidth) + 1;

  typedef enum logic [1:0] {IDLE, PREP, ITER, DONE} state_e;

  state_e               state_q;
  logic [CntWidth-1:0]  cnt_q;
  logic                 last_iter;
  logic [IdWidth-1:0]   id_q;
  ipu_op_e              op_q;
  logic [DataWidth-1:0] a_q, b_q;
  logic [DataWidth-1:0] quo_q, rem_q, res_q;
  logic                 q_neg_q, r_neg_q;
  logic                 signed_op, rem_op, a_neg, b_neg;
  logic [DataWidth:0]   r_shift, r_next;
  logic                 fits;
  logic [DataWidth-1:0] final_res;

  assign signed_op = (op_q == DIV) || (op_q == REM);
  assign rem_op    = (op_q == REM) || (op_q == REMU);
  assign a_neg     = signed_op && a_q[DataWidth-1];
  assign b_neg     = signed_op && b_q[DataWidth-1];
  assign last_iter = (cnt_q == CntWidth'(DataWidth));

  // --------------------
  // One restoring step
  // --------------------
  assign r_shift = {rem_q, quo_q[DataWidth-1]};
  assign fits    = (r_shift >= {1'b0, b_q});
  assign r_next  = fits ? r_shift - {1'b0, b_q} : r_shift;

  // Zero divisor per RISC-V; signed overflow falls out of the magnitudes
  always_comb begin
    if (b_q == '0) begin
      final_res = rem_op ? a_q : '1;
    end else if (rem_op) begin
      final_res = r_neg_q ? -rem_q : rem_q;
    end else begin
      final_res = q_neg_q ? -quo_q : quo_q;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: if (in_valid_i) state_q <= PREP;
        PREP: begin
          cnt_q   <= '0;
          state_q <= ITER;
        end
        ITER: begin
          if (last_iter) begin
            state_q <= DONE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        DONE: if (out_ready_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      IDLE: begin
        id_q <= req_i.id;
        op_q <= req_i.op;
        a_q  <= req_i.arga;
        b_q  <= req_i.argb;
      end
      PREP: begin
        // b_q keeps the divisor magnitude from here on
        quo_q   <= a_neg ? -a_q : a_q;
        b_q     <= b_neg ? -b_q : b_q;
        rem_q   <= '0;
        q_neg_q <= a_neg ^ b_neg;
        r_neg_q <= a_neg;
      end
      ITER: begin
        if (last_iter) begin
          res_q <= final_res;
        end else begin
          quo_q <= {quo_q[DataWidth-2:0], fits};
          rem_q <= r_next[DataWidth-1:0];
        end
      end
      default: ;
    endcase
  end

  assign in_ready_o  = (state_q == IDLE);
  assign out_valid_o = (state_q == DONE);
  assign resp_o      = '{id: id_q, data: res_q, error: 1'b0};

endmodule

`default_nettype wire

// ==== ipu_mul.sv ====
// --------------------
// Two-stage multiplier for MUL, MULH, MULHSU and MULHU
// --------------------
`timescale 1ns/100ps
`default_nettype none

module ipu_mul (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  cc_pkg::acc_req_t  req_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output cc_pkg::acc_resp_t resp_o
);
  import cc_pkg::*;

  logic                          en;
  logic                          a_sign, b_sign;
  logic signed [2*DataWidth+1:0] prod;

  // Stage 1 holds the full product
  logic                          s1_valid_q;
  logic [IdWidth-1:0]            s1_id_q;
  logic                          s1_high_q;
  logic signed [2*DataWidth+1:0] s1_prod_q;

  // Stage 2 holds the selected word
  logic                 s2_valid_q;
  logic [IdWidth-1:0]   s2_id_q;
  logic [DataWidth-1:0] s2_data_q;

  // Whole pipe freezes while the output is stalled
  assign en         = !s2_valid_q || out_ready_i;
  assign in_ready_o = en;

  // --------------------
  // Operand extension
  // --------------------
  // Only MULHU treats rs1 as unsigned, only MULH treats rs2 as signed
  assign a_sign = (req_i.op != MULHU) && req_i.arga[DataWidth-1];
  assign b_sign = (req_i.op == MULH) && req_i.argb[DataWidth-1];
  assign prod   = $signed({a_sign, req_i.arga}) * $signed({b_sign, req_i.argb});

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (en) begin
      s1_valid_q <= in_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en && in_valid_i) begin
      s1_id_q   <= req_i.id;
      s1_high_q <= (req_i.op != MUL);
      s1_prod_q <= prod;
    end
    if (en && s1_valid_q) begin
      s2_id_q   <= s1_id_q;
      s2_data_q <= s1_high_q ? s1_prod_q[2*DataWidth-1:DataWidth] : s1_prod_q[DataWidth-1:0];
    end
  end

  assign out_valid_o = s2_valid_q;
  assign resp_o      = '{id: s2_id_q, data: s2_data_q, error: 1'b0};

endmodule

`default_nettype wire

// ==== spill_register.sv ====
// --------------------
// Two-slot valid/ready register slice, optionally bypassed
// --------------------
`timescale 1ns/100ps
`default_nettype none

module spill_register #(
  parameter bit  Bypass = 1'b0,
  parameter type T      = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    logic a_full_q, b_full_q;
    logic a_fill, a_drain, b_fill, b_drain;
    T     a_data_q, b_data_q;

    // Slot A takes new items, slot B catches A when the output stalls
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill) begin
          a_full_q <= 1'b1;
        end else if (a_drain) begin
          a_full_q <= 1'b0;
        end
        if (b_fill) begin
          b_full_q <= 1'b1;
        end else if (b_drain) begin
          b_full_q <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // B always holds the older item
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
  end

endmodule

`default_nettype wire

// ==== cc_pkg.sv ====
// --------------------
// Shared widths, IPU opcodes and the offload and TCDM payload structs
// --------------------
`default_nettype none

package cc_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int DataWidth = 32;
  localparam int IdWidth   = 5;
  localparam int AmoWidth  = 4;
  localparam int StrbWidth = DataWidth / 8;

  // --------------------
  // IPU opcodes
  // --------------------
  // Codes 8 to 15 are illegal and answered with an error
  typedef enum logic [3:0] {
    MUL    = 4'd0,
    MULH   = 4'd1,
    MULHSU = 4'd2,
    MULHU  = 4'd3,
    DIV    = 4'd4,
    DIVU   = 4'd5,
    REM    = 4'd6,
    REMU   = 4'd7
  } ipu_op_e;

  // --------------------
  // Offload payloads
  // --------------------
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    ipu_op_e              op;
    logic [DataWidth-1:0] arga;
    logic [DataWidth-1:0] argb;
  } acc_req_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic                 error;
  } acc_resp_t;

  // --------------------
  // TCDM payloads
  // --------------------
  typedef struct packed {
    logic [DataWidth-1:0] addr;
    logic                 write;
    logic [AmoWidth-1:0]  amo;
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic [IdWidth-1:0]   id;
  } dreq_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic                 error;
  } dresp_t;

endpackage

`default_nettype wire
